// ==== list.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/decode.sv
verilog/free_list.sv
verilog/rename_stage.sv
verilog/frontend_top.sv
tests/frontend_properties.sv
tests/frontend_tb.sv

// ==== tests/frontend_properties.sv ====
`default_nettype none

module rename_properties (
    input logic              clk,
    input logic              reset,
    input logic              alloc,
    input logic              free_empty,
    input logic              uop_valid,
    input logic              uop_ready,
    input core_pkg::prf_id_t uop_prs1,
    input core_pkg::prf_id_t uop_prs2,
    input core_pkg::prf_id_t uop_prd,
    input core_pkg::prf_id_t uop_old_prd,
    input logic              uop_rd_write,
    input core_pkg::imm_t    uop_imm,
    input core_pkg::funct3_t uop_funct3,
    input logic              uop_is_ls,
    input logic              uop_is_sub,
    input logic              uop_is_sra
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    int failures = 0;  // read by the testbench at the end

    assert property (@(posedge clk) disable iff (reset)
        uop_valid && !uop_ready |=> uop_valid && $stable({uop_prs1, uop_prs2, uop_prd,
            uop_old_prd, uop_rd_write, uop_imm, uop_funct3, uop_is_ls, uop_is_sub, uop_is_sra}))
    else begin
        failures++;
        $error("micro-op changed while the consumer stalled");
    end

    assert property (@(posedge clk) disable iff (reset) alloc |-> !free_empty)
    else begin
        failures++;
        $error("allocation requested from an empty free list");
    end

    assert property (@(posedge clk) reset |=> !uop_valid)
    else begin
        failures++;
        $error("uop_valid high after reset");
    end
endmodule

bind rename_stage rename_properties props_i (.*);

`default_nettype wire

// ==== tests/frontend_tb.sv ====
`default_nettype none

module frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int NUM_RANDOM = 564;
    localparam int NUM_INSTR  = NUM_RANDOM + FREE_DEPTH + 4;
    localparam int MAX_CYCLES = NUM_INSTR * 6 + 400;  // worst case stalls per instruction

    typedef struct packed {
        prf_id_t prs1;
        prf_id_t prs2;
        prf_id_t prd;
        prf_id_t old_prd;
        logic    rd_write;
        imm_t    imm;
        funct3_t funct3;
        logic    is_ls;
        logic    is_sub;
        logic    is_sra;
    } uop_t;

    logic    clk = 1'b0;
    logic    reset, instr_valid, instr_ready, uop_ready, commit_valid;
    instr_t  instr;
    prf_id_t commit_prd;
    logic    uop_valid, uop_rd_write, uop_is_ls, uop_is_sub, uop_is_sra;
    prf_id_t uop_prs1, uop_prs2, uop_prd, uop_old_prd;
    imm_t    uop_imm;
    funct3_t uop_funct3;

    prf_id_t rat_m [NUM_ARF];  // model alias table
    prf_id_t free_q[$];        // model free list
    prf_id_t retire_q[$];      // old ids waiting for commit
    uop_t    exp_q[$];
    integer  seed = 37985;
    integer  stall_seed = 37986;
    int      errors = 0;
    int      cycles = 0;
    int      n_sent = 0;
    int      n_checked = 0;
    int      total;
    logic    random_mode = 1'b0;

    frontend_top dut_i (.*);

    always #5 clk = ~clk;

    function automatic instr_t encode_instr(opcode_t op, arf_id_t rd, arf_id_t rs1,
                                            arf_id_t rs2, funct3_t f3, funct7_t f7);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instr_t random_instr();
        instr_t w;
        w = $random(seed);
        case ({$random(seed)} % 9)
            0: w[6:0] = OP_OPCODE;
            1: w[6:0] = OP_IMM_OPCODE;
            2: w[6:0] = LD_OPCODE;
            3: w[6:0] = ST_OPCODE;
            4: w[6:0] = BR_OPCODE;
            5: w[6:0] = LUI_OPCODE;
            6: w[6:0] = AUIPC_OPCODE;
            7: w[6:0] = JAL_OPCODE;
            default: w[6:0] = JALR_OPCODE;
        endcase
        // legal funct7 for r-type and immediate shifts
        if ((w[6:0] == OP_OPCODE) || ((w[6:0] == OP_IMM_OPCODE) && (w[13:12] == 2'b01))) begin
            w[31:25] = {1'b0, w[30], 5'b0};
        end
        return w;
    endfunction

    function automatic logic writes_reg(instr_t w);
        opcode_t op;
        op = w[6:0];
        return (op inside {OP_OPCODE, OP_IMM_OPCODE, LD_OPCODE, JALR_OPCODE, LUI_OPCODE,
                           AUIPC_OPCODE, JAL_OPCODE}) && (w[11:7] != 5'd0);
    endfunction

    // expected micro-op from the RV32I encoding and the current model state
    function automatic uop_t expected_uop(instr_t w);
        uop_t    u;
        opcode_t op;
        funct3_t f3;
        op = w[6:0];
        f3 = w[14:12];
        u.prs1     = rat_m[w[19:15]];
        u.prs2     = rat_m[w[24:20]];
        u.old_prd  = rat_m[w[11:7]];
        u.rd_write = writes_reg(w);
        u.prd      = (u.rd_write && free_q.size() > 0) ? free_q[0] : '0;
        u.funct3   = f3;
        u.is_ls    = (op == LD_OPCODE) || (op == ST_OPCODE);
        u.is_sub   = (op == OP_OPCODE) && (f3 == 3'b000) && w[30];
        u.is_sra   = ((op == OP_OPCODE) || (op == OP_IMM_OPCODE)) && (f3 == 3'b101) && w[30];
        case (op)
            OP_IMM_OPCODE, LD_OPCODE, JALR_OPCODE: u.imm = {{20{w[31]}}, w[31:20]};
            ST_OPCODE:    u.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            BR_OPCODE:    u.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            LUI_OPCODE, AUIPC_OPCODE: u.imm = {w[31:12], 12'h000};
            JAL_OPCODE:   u.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:      u.imm = '0;  // r-type
        endcase
        return u;
    endfunction

    task automatic compare_field(string name, logic [31:0] exp_v, logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic wait_for_accept();
        @(negedge clk);
        while (!instr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic send_instr(instr_t w);
        instr_valid = 1'b1;
        instr       = w;
        wait_for_accept();
    endtask

    // handshakes are stable at the falling edge, so model and checks run there
    always @(negedge clk) begin : model_and_compare
        uop_t e;
        if (!reset) begin
            if (instr_valid && instr_ready) begin
                exp_q.push_back(expected_uop(instr));
                n_sent++;
                if (writes_reg(instr)) begin
                    assert (free_q.size() > 0) else begin
                        errors++;
                        $display("register-writing instruction accepted with no free id at %0t",
                                 $time);
                    end
                    if (free_q.size() > 0) rat_m[instr[11:7]] = free_q.pop_front();
                end
            end
            if (commit_valid) free_q.push_back(commit_prd);
            if (uop_valid && uop_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("micro-op delivered at %0t with no instruction outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    n_checked++;
                    compare_field("uop_prs1", e.prs1, uop_prs1);
                    compare_field("uop_prs2", e.prs2, uop_prs2);
                    compare_field("uop_prd", e.prd, uop_prd);
                    compare_field("uop_old_prd", e.old_prd, uop_old_prd);
                    compare_field("uop_rd_write", e.rd_write, uop_rd_write);
                    compare_field("uop_imm", e.imm, uop_imm);
                    compare_field("uop_funct3", e.funct3, uop_funct3);
                    compare_field("uop_is_ls", e.is_ls, uop_is_ls);
                    compare_field("uop_is_sub", e.is_sub, uop_is_sub);
                    compare_field("uop_is_sra", e.is_sra, uop_is_sra);
                    if (e.rd_write) retire_q.push_back(e.old_prd);
                end
            end
        end
    end

    // random back-pressure and commits
    always @(posedge clk) begin
        #1;
        if (random_mode) begin
            uop_ready    = ({$random(stall_seed)} % 10) < 7;
            commit_valid = 1'b0;
            if ((retire_q.size() > 0) && (({$random(stall_seed)} % 10) < 6)) begin
                commit_valid = 1'b1;
                commit_prd   = retire_q.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        uop_ready    = 1'b1;
        commit_valid = 1'b0;
        commit_prd   = '0;
        for (int i = 0; i < NUM_ARF; i++) rat_m[i] = prf_id_t'(i);
        for (int i = 0; i < FREE_DEPTH; i++) free_q.push_back(prf_id_t'(NUM_ARF + i));
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // dependent chains through x1..x5 use up every free id
        for (int k = 0; k < FREE_DEPTH; k++) begin
            send_instr(encode_instr((k % 4 == 0) ? OP_OPCODE : (k % 4 == 1) ? OP_IMM_OPCODE :
                                    (k % 4 == 2) ? LUI_OPCODE : JALR_OPCODE,
                                    arf_id_t'(k % 5 + 1), arf_id_t'((k + 4) % 5 + 1),
                                    arf_id_t'(k % 5 + 1), funct3_t'(k),
                                    (k % 3 == 0) ? 7'h20 : 7'h00));
        end
        // no allocation needed, so these pass an empty list
        send_instr(encode_instr(ST_OPCODE, 5'd4, 5'd1, 5'd2, 3'b010, 7'h01));
        send_instr(encode_instr(OP_IMM_OPCODE, 5'd0, 5'd3, 5'd7, 3'b000, 7'h00));
        send_instr(encode_instr(BR_OPCODE, 5'd9, 5'd2, 5'd3, 3'b001, 7'h40));

        instr_valid = 1'b1;
        instr       = encode_instr(OP_OPCODE, 5'd7, 5'd1, 5'd2, 3'b000, 7'h00);
        repeat (4) begin
            @(negedge clk);
            assert (!instr_ready) else begin
                errors++;
                $display("instr_ready high with an empty free list at %0t", $time);
            end
        end
        @(posedge clk);
        #1;
        commit_valid = 1'b1;  // single id returned
        commit_prd   = retire_q.pop_front();
        @(posedge clk);
        #1;
        commit_valid = 1'b0;
        wait_for_accept();

        @(negedge clk);
        random_mode = 1'b1;
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ({$random(seed)} % 4 == 0) begin
                @(posedge clk);  // idle gap on the input side
                #1;
            end
            send_instr(random_instr());
        end
        while (n_checked < n_sent) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (!uop_valid) else begin
            errors++;
            $display("micro-op still pending at %0t after every instruction was checked", $time);
        end

        total = errors + dut_i.u_rename_stage.props_i.failures;
        $display("checked %0d of %0d micro-ops, %0d errors", n_checked, n_sent, total);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // machine and register file sizes
    localparam int XLEN       = 32;
    localparam int NUM_ARF    = 32;
    localparam int NUM_PRF    = 64;
    localparam int FREE_DEPTH = NUM_PRF - NUM_ARF; // ids not mapped after reset

    localparam int ARF_W      = $clog2(NUM_ARF);
    localparam int PRF_W      = $clog2(NUM_PRF);
    localparam int FREE_PTR_W = $clog2(FREE_DEPTH);

    typedef logic [XLEN-1:0]     instr_t;
    typedef logic [XLEN-1:0]     imm_t;      // sign-extended immediate
    typedef logic [ARF_W-1:0]    arf_id_t;
    typedef logic [PRF_W-1:0]    prf_id_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [6:0]          funct7_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [FREE_PTR_W-1:0] free_ptr_t;
    typedef logic [FREE_PTR_W:0]   free_cnt_t; // needs to hold FREE_DEPTH itself

    // major opcodes handled by decode
    localparam opcode_t OP_OPCODE     = 7'b0110011;
    localparam opcode_t OP_IMM_OPCODE = 7'b0010011;
    localparam opcode_t LD_OPCODE     = 7'b0000011;
    localparam opcode_t ST_OPCODE     = 7'b0100011;
    localparam opcode_t BR_OPCODE     = 7'b1100011;
    localparam opcode_t LUI_OPCODE    = 7'b0110111;
    localparam opcode_t AUIPC_OPCODE  = 7'b0010111;
    localparam opcode_t JAL_OPCODE    = 7'b1101111;
    localparam opcode_t JALR_OPCODE   = 7'b1100111;

    // funct3 values that need funct7[5] to tell variants apart
    localparam funct3_t SUB_FUNCT3  = 3'b000; // add / sub
    localparam funct3_t SRA_FUNCT3  = 3'b101; // srl / sra
    localparam funct3_t SRAI_FUNCT3 = 3'b101; // srli / srai

endpackage

`default_nettype wire

// ==== verilog/decode.sv ====
`default_nettype none

`include "misc/global_defs.svh"

module decode (
    input  core_pkg::instr_t  instr,
    output logic              rs1_valid,   // register field is actually used
    output logic              rs2_valid,
    output logic              rd_valid,
    output core_pkg::arf_id_t rs1,
    output core_pkg::arf_id_t rs2,
    output core_pkg::arf_id_t rd,
    output core_pkg::funct3_t funct3,      // alu op, branch cond or access size
    output core_pkg::imm_t    imm,
    output logic              is_r_type,
    output logic              is_i_type,   // op-imm, loads and jalr
    output logic              is_s_type,
    output logic              is_b_type,
    output logic              is_u_type,   // lui, auipc
    output logic              is_j_type,   // jal
    output logic              is_sub,
    output logic              is_sra_srai,
    output logic              is_lui,      // else auipc when u-type
    output logic              is_jalr,
    output logic              is_int_instr,
    output logic              is_ls_instr,
    output logic [1:0]        ls_width,    // byte, half, word
    output logic              ld_sign      // set means zero-extending load
);
    import core_pkg::*;

    opcode_t opcode;
    funct7_t funct7;
    imm_t    i_imm;
    imm_t    s_imm;
    imm_t    b_imm;
    imm_t    u_imm;
    imm_t    j_imm;

    assign opcode = instr[`opcode_bits];
    assign funct7 = instr[`funct7_bits];
    assign funct3 = instr[`funct3_bits];

    assign rs1 = instr[`rs1_bits];
    assign rs2 = instr[`rs2_bits];
    assign rd  = instr[`rd_bits];

    assign is_r_type = opcode == OP_OPCODE;
    assign is_i_type = (opcode == OP_IMM_OPCODE) || (opcode == LD_OPCODE) ||
                       (opcode == JALR_OPCODE);
    assign is_s_type = opcode == ST_OPCODE;
    assign is_b_type = opcode == BR_OPCODE;
    assign is_u_type = (opcode == LUI_OPCODE) || (opcode == AUIPC_OPCODE);
    assign is_j_type = opcode == JAL_OPCODE;

    assign rs1_valid = is_r_type || is_i_type || is_s_type || is_b_type;
    assign rs2_valid = is_r_type || is_s_type || is_b_type;
    assign rd_valid  = is_r_type || is_i_type || is_u_type || is_j_type;

    assign i_imm = `I_IMM(instr);
    assign s_imm = `S_IMM(instr);
    assign b_imm = `B_IMM(instr);
    assign u_imm = `U_IMM(instr);
    assign j_imm = `J_IMM(instr);

    assign imm = is_i_type ? i_imm :
                 is_s_type ? s_imm :
                 is_b_type ? b_imm :
                 is_u_type ? u_imm :
                 is_j_type ? j_imm :
                             '0;    // r-type and unknown opcodes

    assign is_sub      = is_r_type && (funct3 == SUB_FUNCT3) && funct7[5];
    assign is_sra_srai = (is_r_type && (funct3 == SRA_FUNCT3) && funct7[5]) ||
                         ((opcode == OP_IMM_OPCODE) && (funct3 == SRAI_FUNCT3) && funct7[5]);
    assign is_lui      = opcode == LUI_OPCODE;
    assign is_jalr     = opcode == JALR_OPCODE;

    assign is_ls_instr  = (opcode == LD_OPCODE) || (opcode == ST_OPCODE);
    assign is_int_instr = ~is_ls_instr;

    assign ls_width = funct3[1:0];
    assign ld_sign  = funct3[2];
endmodule

`default_nettype wire

// ==== verilog/free_list.sv ====
`default_nettype none

module free_list (
    input  logic               clk,
    input  logic               reset,
    input  logic               pop,        // rename takes free_id
    input  logic               push,       // commit returns an id
    input  core_pkg::prf_id_t  push_id,
    output core_pkg::prf_id_t  free_id,    // oldest free id
    output logic               free_empty
);
    import core_pkg::*;

    prf_id_t   ids [FREE_DEPTH];
    free_ptr_t rd_ptr;
    free_ptr_t wr_ptr;
    free_cnt_t count;
    logic      do_pop;
    logic      do_push;

    assign free_empty = count == '0;
    assign free_id    = ids[rd_ptr];

    assign do_pop  = pop && !free_empty;
    // a full list only accepts a push that is matched by a pop
    assign do_push = push && ((count != free_cnt_t'(FREE_DEPTH)) || do_pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;  // wraps, list starts full
            count  <= free_cnt_t'(FREE_DEPTH);
        end else begin
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or pop and push together
            endcase
        end
    end

    // storage is loaded with the ids above the architectural range
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                ids[i] <= prf_id_t'(NUM_ARF + i);
            end
        end else if (do_push) begin
            ids[wr_ptr] <= push_id;
        end
    end
endmodule

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`default_nettype none

module frontend_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  core_pkg::instr_t  instr,
    input  logic              uop_ready,
    input  logic              commit_valid,
    input  core_pkg::prf_id_t commit_prd,   // old_prd of a retired uop
    output logic              uop_valid,
    output core_pkg::prf_id_t uop_prs1,
    output core_pkg::prf_id_t uop_prs2,
    output core_pkg::prf_id_t uop_prd,
    output core_pkg::prf_id_t uop_old_prd,
    output logic              uop_rd_write,
    output core_pkg::imm_t    uop_imm,
    output core_pkg::funct3_t uop_funct3,
    output logic              uop_is_ls,
    output logic              uop_is_sub,
    output logic              uop_is_sra
);
    import core_pkg::*;

    arf_id_t rs1;
    arf_id_t rs2;
    arf_id_t rd;
    logic    rd_valid;
    imm_t    imm;
    funct3_t funct3;
    logic    is_ls_instr;
    logic    is_sub;
    logic    is_sra_srai;
    prf_id_t free_id;
    logic    free_empty;
    logic    alloc;

    decode u_decode (
        .instr        (instr),
        .rs1_valid    (),
        .rs2_valid    (),
        .rd_valid     (rd_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .funct3       (funct3),
        .imm          (imm),
        .is_r_type    (),
        .is_i_type    (),
        .is_s_type    (),
        .is_b_type    (),
        .is_u_type    (),
        .is_j_type    (),
        .is_sub       (is_sub),
        .is_sra_srai  (is_sra_srai),
        .is_lui       (),
        .is_jalr      (),
        .is_int_instr (),
        .is_ls_instr  (is_ls_instr),
        .ls_width     (),
        .ld_sign      ()
    );

    rename_stage u_rename_stage (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .uop_ready    (uop_ready),
        .rd_valid     (rd_valid),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .funct3       (funct3),
        .is_ls_instr  (is_ls_instr),
        .is_sub       (is_sub),
        .is_sra_srai  (is_sra_srai),
        .free_id      (free_id),
        .free_empty   (free_empty),
        .alloc        (alloc),
        .uop_valid    (uop_valid),
        .uop_prs1     (uop_prs1),
        .uop_prs2     (uop_prs2),
        .uop_prd      (uop_prd),
        .uop_old_prd  (uop_old_prd),
        .uop_rd_write (uop_rd_write),
        .uop_imm      (uop_imm),
        .uop_funct3   (uop_funct3),
        .uop_is_ls    (uop_is_ls),
        .uop_is_sub   (uop_is_sub),
        .uop_is_sra   (uop_is_sra)
    );

    free_list u_free_list (
        .clk        (clk),
        .reset      (reset),
        .pop        (alloc),
        .push       (commit_valid), // returned on the same edge
        .push_id    (commit_prd),
        .free_id    (free_id),
        .free_empty (free_empty)
    );
endmodule

`default_nettype wire

// ==== verilog/misc/global_defs.svh ====
`ifndef GLOBAL_DEFS_SVH
`define GLOBAL_DEFS_SVH

// RV32I instruction field positions
`define opcode_bits 6:0
`define rd_bits     11:7
`define funct3_bits 14:12
`define rs1_bits    19:15
`define rs2_bits    24:20
`define funct7_bits 31:25

// immediate assembly, all formats sign extended to 32 bits

// loads, op-imm, jalr
`define I_IMM(i) {{20{i[31]}}, i[31:20]}

// stores
`define S_IMM(i) {{20{i[31]}}, i[31:25], i[11:7]}

// branches, bit 0 always zero
`define B_IMM(i) {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0}

// lui and auipc, low 12 bits zero
`define U_IMM(i) {i[31:12], 12'b0}

// jal, bit 0 always zero
`define J_IMM(i) {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0}

`endif

// ==== verilog/rename_stage.sv ====
`default_nettype none

module rename_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic              uop_ready,
    input  logic              rd_valid,
    input  core_pkg::arf_id_t rs1,
    input  core_pkg::arf_id_t rs2,
    input  core_pkg::arf_id_t rd,
    input  core_pkg::imm_t    imm,
    input  core_pkg::funct3_t funct3,
    input  logic              is_ls_instr,
    input  logic              is_sub,
    input  logic              is_sra_srai,
    input  core_pkg::prf_id_t free_id,
    input  logic              free_empty,
    output logic              alloc,       // pops the free list
    output logic              uop_valid,
    output core_pkg::prf_id_t uop_prs1,
    output core_pkg::prf_id_t uop_prs2,
    output core_pkg::prf_id_t uop_prd,
    output core_pkg::prf_id_t uop_old_prd, // freed when this uop retires
    output logic              uop_rd_write,
    output core_pkg::imm_t    uop_imm,
    output core_pkg::funct3_t uop_funct3,
    output logic              uop_is_ls,
    output logic              uop_is_sub,
    output logic              uop_is_sra
);
    import core_pkg::*;

    prf_id_t rat [NUM_ARF];  // architectural to physical map
    logic    needs_reg;
    logic    out_free;
    logic    accept;

    assign needs_reg = rd_valid && (rd != '0);  // x0 never gets a new register
    assign out_free  = !uop_valid || uop_ready; // output empty or draining
    assign instr_ready = out_free && !(needs_reg && free_empty);
    assign accept    = instr_valid && instr_ready;
    assign alloc     = accept && needs_reg;

    // entry 0 is never written, so it stays mapped to p0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARF; i++) begin
                rat[i] <= prf_id_t'(i);
            end
        end else if (alloc) begin
            rat[rd] <= free_id;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_valid <= 1'b0;
        end else if (accept) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    // payload holds while the consumer stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            uop_prs1     <= rat[rs1];  // table still holds the pre-update map
            uop_prs2     <= rat[rs2];
            uop_prd      <= needs_reg ? free_id : '0;
            uop_old_prd  <= rat[rd];
            uop_rd_write <= needs_reg;
            uop_imm      <= imm;
            uop_funct3   <= funct3;
            uop_is_ls    <= is_ls_instr;
            uop_is_sub   <= is_sub;
            uop_is_sra   <= is_sra_srai;
        end
    end
endmodule

`default_nettype wire
